//--- src/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and vector types
	////////////////////////////////////////////////////////////////////////////

	localparam int IADDR_WIDTH = 11;
	localparam int IMEM_DEPTH = 2048;

	typedef logic [31:0] word_t;
	typedef logic [IADDR_WIDTH-1:0] iaddr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] opcode_t;
	typedef logic [2:0] alu_op_t;

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// opcode lives in instr[31:27]
	localparam opcode_t OP_ADD  = 5'b00000;
	localparam opcode_t OP_ADDI = 5'b00001;
	localparam opcode_t OP_SUB  = 5'b00010;
	localparam opcode_t OP_AND  = 5'b00011;
	localparam opcode_t OP_ANDI = 5'b00100;
	localparam opcode_t OP_OR   = 5'b00101;
	localparam opcode_t OP_ORI  = 5'b00110;
	localparam opcode_t OP_XOR  = 5'b00111;
	localparam opcode_t OP_SLL  = 5'b01000;
	localparam opcode_t OP_SRL  = 5'b01001;
	localparam opcode_t OP_SRA  = 5'b01010;
	localparam opcode_t OP_LLI  = 5'b01011;
	localparam opcode_t OP_LUI  = 5'b01100;
	localparam opcode_t OP_B    = 5'b10001;
	localparam opcode_t OP_BL   = 5'b10010;
	localparam opcode_t OP_RET  = 5'b10011;

	localparam alu_op_t ALU_ADD = 3'b000;
	localparam alu_op_t ALU_SUB = 3'b001;
	localparam alu_op_t ALU_AND = 3'b010;
	localparam alu_op_t ALU_OR  = 3'b011;
	localparam alu_op_t ALU_XOR = 3'b100;
	localparam alu_op_t ALU_SLL = 3'b101;
	localparam alu_op_t ALU_SRL = 3'b110;
	localparam alu_op_t ALU_SRA = 3'b111;

	// branch condition in instr[26:24]
	localparam logic [2:0] COND_NE     = 3'b000;
	localparam logic [2:0] COND_EQ     = 3'b001;
	localparam logic [2:0] COND_GT     = 3'b010;
	localparam logic [2:0] COND_LT     = 3'b011;
	localparam logic [2:0] COND_GE     = 3'b100;
	localparam logic [2:0] COND_LE     = 3'b101;
	localparam logic [2:0] COND_OV     = 3'b110;
	localparam logic [2:0] COND_ALWAYS = 3'b111;

	////////////////////////////////////////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} cc_t;

	typedef struct packed {
		alu_op_t   alu_op;
		logic      use_immediate;
		logic      write_lower;
		logic      write_upper;
		logic      select_immediate;
		logic      update_cc;
		logic      write_reg;
		reg_addr_t dest;
		reg_addr_t src1;
		reg_addr_t src2;
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t ctrl;
		word_t    op1;
		word_t    op2;
		word_t    immediate;
	} ex_op_t;

	typedef struct packed {
		reg_addr_t dest;
		word_t     data;
	} retire_t;

endpackage

//--- src/alu.sv
module alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result,
	output cpu_pkg::cc_t     flags
);
	import cpu_pkg::*;

	logic add_ovf;
	logic sub_ovf;
	logic overflow;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// shift amount from the low five bits only
			ALU_SLL: result = a << b[4:0];
			ALU_SRL: result = a >> b[4:0];
			ALU_SRA: result = word_t'($signed(a) >>> b[4:0]);
			default: result = '0;
		endcase
	end

	// signed overflow
	assign add_ovf = (a[31] == b[31]) && (result[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (result[31] != a[31]);

	assign overflow = (op == ALU_ADD) ? add_ovf :
		(op == ALU_SUB) ? sub_ovf : 1'b0;

	assign flags = '{zero: (result == '0), sign: result[31], overflow: overflow};

endmodule

//--- src/register_file.sv
module register_file (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t rd_addr1,
	input  cpu_pkg::reg_addr_t rd_addr2,
	input  cpu_pkg::retire_t   wr,
	input  logic               wr_en,
	output cpu_pkg::word_t     rd_data1,
	output cpu_pkg::word_t     rd_data2
);
	import cpu_pkg::*;

	word_t regs [32];

	logic write_live;
	logic hit1;
	logic hit2;

	// r0 stays zero, so it never takes a write
	assign write_live = wr_en && (wr.dest != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_live) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// write-through
	// a same-cycle write shows up on the read port
	assign hit1 = write_live && (wr.dest == rd_addr1);
	assign hit2 = write_live && (wr.dest == rd_addr2);

	assign rd_data1 = hit1 ? wr.data : regs[rd_addr1];
	assign rd_data2 = hit2 ? wr.data : regs[rd_addr2];

endmodule

//--- src/instruction_fetch.sv
module instruction_fetch (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            run,
	input  logic            stall,
	input  logic            redirect,
	input  cpu_pkg::iaddr_t redirect_addr,
	input  logic            link,
	input  cpu_pkg::iaddr_t link_addr,
	input  logic            ret,
	input  logic            imem_we,
	input  cpu_pkg::iaddr_t imem_addr,
	input  cpu_pkg::word_t  imem_data,
	output cpu_pkg::word_t  instr,
	output cpu_pkg::iaddr_t instr_pc,
	output logic            instr_valid
);
	import cpu_pkg::*;

	word_t imem [IMEM_DEPTH];

	// pc_q is the next sequential address, one past the last fetch
	iaddr_t pc_q;
	iaddr_t link_q;
	iaddr_t fetch_addr;

	always_comb begin
		if (!run) begin
			fetch_addr = '0;
		end else if (redirect) begin
			fetch_addr = redirect_addr;
		end else if (ret) begin
			fetch_addr = link_q;
		end else if (stall) begin
			// refetch whatever sits in decode
			fetch_addr = instr_pc;
		end else begin
			fetch_addr = pc_q;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= '0;
			instr_valid <= 1'b0;
		end else begin
			pc_q <= run ? fetch_addr + iaddr_t'(1) : '0;
			instr_valid <= run;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_q <= '0;
		end else if (link) begin
			link_q <= link_addr;
		end
	end

	// synchronous read lands straight in the decode register
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data;
		end
		instr <= imem[fetch_addr];
		instr_pc <= fetch_addr;
	end

	// both come from one decoded opcode
	a_redirect_ret_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n) !(redirect && ret));

endmodule

//--- src/decode_stage.sv
module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::iaddr_t    instr_pc,
	input  logic               instr_valid,
	input  cpu_pkg::word_t     rd_data1,
	input  cpu_pkg::word_t     rd_data2,
	input  cpu_pkg::ex_ctrl_t  pending,
	input  logic               pending_valid,
	input  cpu_pkg::cc_t       next_cc,
	input  logic               cc_update,
	output cpu_pkg::reg_addr_t rd_addr1,
	output cpu_pkg::reg_addr_t rd_addr2,
	output logic               stall,
	output logic               redirect,
	output cpu_pkg::iaddr_t    redirect_addr,
	output logic               link,
	output cpu_pkg::iaddr_t    link_addr,
	output logic               ret,
	output cpu_pkg::ex_op_t    ex_op,
	output logic               ex_valid
);
	import cpu_pkg::*;

	opcode_t  opcode;
	ex_ctrl_t ctrl;
	word_t    immediate;
	logic     alu_class;
	logic     is_branch;
	logic     is_link;
	logic     is_ret;
	logic     taken;
	cc_t      cc_q;

	// decode/execute register
	ex_ctrl_t ctrl_q;
	logic     valid_q;
	word_t    op1_q;
	word_t    op2_q;
	word_t    imm_q;

	assign opcode = instr[31:27];
	assign immediate = {{16{instr[15]}}, instr[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		alu_class = 1'b0;
		is_branch = 1'b0;
		is_link = 1'b0;
		is_ret = 1'b0;
		case (opcode)
			OP_ADD, OP_ADDI: alu_class = 1'b1;
			OP_SUB: begin
				ctrl.alu_op = ALU_SUB;
				alu_class = 1'b1;
			end
			OP_AND, OP_ANDI: begin
				ctrl.alu_op = ALU_AND;
				alu_class = 1'b1;
			end
			OP_OR, OP_ORI: begin
				ctrl.alu_op = ALU_OR;
				alu_class = 1'b1;
			end
			OP_XOR: begin
				ctrl.alu_op = ALU_XOR;
				alu_class = 1'b1;
			end
			OP_SLL: begin
				ctrl.alu_op = ALU_SLL;
				alu_class = 1'b1;
			end
			OP_SRL: begin
				ctrl.alu_op = ALU_SRL;
				alu_class = 1'b1;
			end
			OP_SRA: begin
				ctrl.alu_op = ALU_SRA;
				alu_class = 1'b1;
			end
			OP_LLI: ctrl.write_lower = 1'b1;
			OP_LUI: ctrl.write_upper = 1'b1;
			OP_B: is_branch = 1'b1;
			OP_BL: begin
				is_branch = 1'b1;
				is_link = 1'b1;
			end
			OP_RET: is_ret = 1'b1;
			// everything else is a no-op
			default: ;
		endcase

		ctrl.select_immediate = ctrl.write_lower || ctrl.write_upper;
		ctrl.use_immediate = opcode inside {OP_ADDI, OP_ANDI, OP_ORI};
		ctrl.update_cc = alu_class;
		ctrl.write_reg = alu_class || ctrl.select_immediate;
		ctrl.dest = instr[26:22];
		ctrl.src1 = instr[21:17];
		// lli/lui merge into the old destination value
		ctrl.src2 = ctrl.select_immediate ? instr[26:22] : instr[16:12];
	end

	assign rd_addr1 = ctrl.src1;
	assign rd_addr2 = ctrl.src2;

	////////////////////////////////////////////////////////////////////////////
	// flags and branch resolution
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cc_q <= '0;
		end else if (cc_update) begin
			cc_q <= next_cc;
		end
	end

	always_comb begin
		case (instr[26:24])
			COND_NE:     taken = !cc_q.zero;
			COND_EQ:     taken = cc_q.zero;
			COND_GT:     taken = !cc_q.zero && !cc_q.sign;
			COND_LT:     taken = !cc_q.zero && cc_q.sign;
			COND_GE:     taken = cc_q.zero || !cc_q.sign;
			COND_LE:     taken = cc_q.zero || cc_q.sign;
			COND_OV:     taken = cc_q.overflow;
			COND_ALWAYS: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	// flags for a branch right behind an update are one cycle late
	assign stall = instr_valid && is_branch && pending_valid && pending.update_cc;

	assign redirect = instr_valid && is_branch && taken && !stall;
	assign redirect_addr = instr_pc + iaddr_t'(1) + immediate[IADDR_WIDTH-1:0];
	assign link = redirect && is_link;
	assign link_addr = instr_pc + iaddr_t'(1);
	assign ret = instr_valid && is_ret;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			valid_q <= 1'b0;
		end else if (stall || !instr_valid) begin
			ctrl_q <= '0;
			valid_q <= 1'b0;
		end else begin
			ctrl_q <= ctrl;
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		op1_q <= rd_data1;
		op2_q <= rd_data2;
		imm_q <= immediate;
	end

	assign ex_op = '{ctrl: ctrl_q, op1: op1_q, op2: op2_q, immediate: imm_q};
	assign ex_valid = valid_q;

	// the bubble clears the pending update, so a stall never repeats
	a_single_cycle_stall: assert property (
		@(posedge clk) disable iff (!rst_n) stall |=> !stall);

endmodule

//--- src/execute_stage.sv
module execute_stage (
	input  cpu_pkg::ex_op_t   ex_op,
	input  logic              ex_valid,
	input  cpu_pkg::retire_t  bypass,
	input  logic              bypass_valid,
	output cpu_pkg::ex_ctrl_t pending,
	output logic              pending_valid,
	output cpu_pkg::cc_t      next_cc,
	output logic              cc_update,
	output cpu_pkg::retire_t  res,
	output logic              res_valid
);
	import cpu_pkg::*;

	ex_ctrl_t ctrl;
	logic     fwd1;
	logic     fwd2;
	word_t    op1;
	word_t    op2;
	word_t    operand_b;
	word_t    alu_result;
	word_t    merged;
	cc_t      alu_flags;

	assign ctrl = ex_op.ctrl;

	// bypass from result
	// r0 reads must stay zero even when r0 was just written
	assign fwd1 = bypass_valid && (bypass.dest != '0) && (bypass.dest == ctrl.src1);
	assign fwd2 = bypass_valid && (bypass.dest != '0) && (bypass.dest == ctrl.src2);

	assign op1 = fwd1 ? bypass.data : ex_op.op1;
	assign op2 = fwd2 ? bypass.data : ex_op.op2;

	assign operand_b = ctrl.use_immediate ? ex_op.immediate : op2;

	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (op1),
		.b      (operand_b),
		.result (alu_result),
		.flags  (alu_flags)
	);

	// half-word merge for lli/lui, op2 holds the old destination
	always_comb begin
		merged = op2;
		if (ctrl.write_lower) begin
			merged[15:0] = ex_op.immediate[15:0];
		end
		if (ctrl.write_upper) begin
			merged[31:16] = ex_op.immediate[15:0];
		end
	end

	assign res.dest = ctrl.dest;
	assign res.data = ctrl.select_immediate ? merged : alu_result;
	assign res_valid = ex_valid && ctrl.write_reg;

	assign next_cc = alu_flags;
	assign cc_update = ex_valid && ctrl.update_cc;

	// decode looks at this for the branch hazard
	assign pending = ctrl;
	assign pending_valid = ex_valid;

endmodule

//--- src/result_stage.sv
module result_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::retire_t res,
	input  logic             res_valid,
	output cpu_pkg::retire_t rf_wr,
	output logic             rf_wr_en,
	output cpu_pkg::retire_t bypass,
	output logic             bypass_valid
);
	import cpu_pkg::*;

	// execute/result register
	retire_t res_q;
	logic    valid_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= res_valid;
		end
	end

	always_ff @(posedge clk) begin
		res_q <= res;
	end

	// one register feeds the write port, the bypass and retire
	assign rf_wr = res_q;
	assign rf_wr_en = valid_q;

	assign bypass = res_q;
	assign bypass_valid = valid_q;

	// pipeline is empty coming out of reset, so nothing can
	// reach this stage for the first two edges
	a_quiet_after_reset: assert property (
		@(posedge clk) $rose(rst_n) |-> !rf_wr_en ##1 !rf_wr_en);

endmodule

//--- src/cpu_top.sv
module cpu_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             run,
	input  logic             imem_we,
	input  cpu_pkg::iaddr_t  imem_addr,
	input  cpu_pkg::word_t   imem_data,
	output logic             retire,
	output cpu_pkg::retire_t retire_info
);
	import cpu_pkg::*;

	// fetch <-> decode
	word_t     instr;
	iaddr_t    instr_pc;
	logic      instr_valid;
	logic      stall;
	logic      redirect;
	iaddr_t    redirect_addr;
	logic      link;
	iaddr_t    link_addr;
	logic      ret;

	// register file
	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	word_t     rd_data1;
	word_t     rd_data2;
	retire_t   rf_wr;
	logic      rf_wr_en;

	// decode <-> execute <-> result
	ex_op_t    ex_op;
	logic      ex_valid;
	ex_ctrl_t  pending;
	logic      pending_valid;
	cc_t       next_cc;
	logic      cc_update;
	retire_t   res;
	logic      res_valid;
	retire_t   bypass;
	logic      bypass_valid;

	instruction_fetch u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.run           (run),
		.stall         (stall),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.link          (link),
		.link_addr     (link_addr),
		.ret           (ret),
		.imem_we       (imem_we),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.instr         (instr),
		.instr_pc      (instr_pc),
		.instr_valid   (instr_valid)
	);

	register_file u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.wr       (rf_wr),
		.wr_en    (rf_wr_en),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	decode_stage u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.instr_pc      (instr_pc),
		.instr_valid   (instr_valid),
		.rd_data1      (rd_data1),
		.rd_data2      (rd_data2),
		.pending       (pending),
		.pending_valid (pending_valid),
		.next_cc       (next_cc),
		.cc_update     (cc_update),
		.rd_addr1      (rd_addr1),
		.rd_addr2      (rd_addr2),
		.stall         (stall),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.link          (link),
		.link_addr     (link_addr),
		.ret           (ret),
		.ex_op         (ex_op),
		.ex_valid      (ex_valid)
	);

	execute_stage u_execute (
		.ex_op         (ex_op),
		.ex_valid      (ex_valid),
		.bypass        (bypass),
		.bypass_valid  (bypass_valid),
		.pending       (pending),
		.pending_valid (pending_valid),
		.next_cc       (next_cc),
		.cc_update     (cc_update),
		.res           (res),
		.res_valid     (res_valid)
	);

	result_stage u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.res          (res),
		.res_valid    (res_valid),
		.rf_wr        (rf_wr),
		.rf_wr_en     (rf_wr_en),
		.bypass       (bypass),
		.bypass_valid (bypass_valid)
	);

	// every register write retires
	assign retire = rf_wr_en;
	assign retire_info = rf_wr;

endmodule

//--- verification/cpu_tb.sv
module cpu_tb;
	import cpu_pkg::*;

	localparam int PROG_LEN = 256;
	localparam int MODEL_STEPS = 4000;
	localparam int RUN_TIMEOUT = 5000;
	localparam int QUIET_CYCLES = 20;

	logic    clk;
	logic    rst_n;
	logic    run;
	logic    imem_we;
	iaddr_t  imem_addr;
	word_t   imem_data;
	logic    retire;
	retire_t retire_info;

	word_t     prog [PROG_LEN];
	int        plen;
	reg_addr_t exp_dest [$];
	word_t     exp_data [$];
	int        got;
	int        errors;
	int        tests_run;
	int        tests_failed;
	int        seed = 66;

	opcode_t alu_ops [11] = '{OP_ADD, OP_ADDI, OP_SUB, OP_AND, OP_ANDI, OP_OR, OP_ORI,
		OP_XOR, OP_SLL, OP_SRL, OP_SRA};

	cpu_top dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.retire      (retire),
		.retire_info (retire_info)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// retire monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n && retire) begin
			assert (got < exp_dest.size()) else begin
				$display("unexpected register write r%0d=%h at time %0t, only %0d expected",
					retire_info.dest, retire_info.data, $time, exp_dest.size());
				errors++;
			end
			if (got < exp_dest.size()) begin
				assert (retire_info.dest == exp_dest[got] && retire_info.data == exp_data[got])
				else begin
					$display("[FAIL] %0t: write %0d is r%0d=%h, expected r%0d=%h", $time, got,
						retire_info.dest, retire_info.data, exp_dest[got], exp_data[got]);
					errors++;
				end
			end
			got++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// program building
	////////////////////////////////////////////////////////////////////////////

	function automatic int pick(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[30:0]) % n;
	endfunction

	function automatic logic [15:0] random_half();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic word_t reg_form(opcode_t op, reg_addr_t d, reg_addr_t s1, reg_addr_t s2);
		return {op, d, s1, s2, 12'h000};
	endfunction

	function automatic word_t imm_form(opcode_t op, reg_addr_t d, reg_addr_t s1,
		logic [15:0] imm);
		return {op, d, s1, 1'b0, imm};
	endfunction

	// condition sits where dest would be
	function automatic word_t branch_form(opcode_t op, logic [2:0] cond, logic [15:0] off);
		return {op, cond, 8'h00, off};
	endfunction

	task automatic emit(input word_t w);
		prog[plen] = w;
		plen++;
	endtask

	// unused words are no-ops tagged with their address
	task automatic clear_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = {5'b11111, 27'(i)};
		end
		plen = 0;
	endtask

	// branch to itself
	task automatic finish_program();
		emit(branch_form(OP_B, COND_ALWAYS, 16'hffff));
	endtask

	task automatic random_alu_op(input int lo, input int hi);
		opcode_t   op;
		reg_addr_t d;
		reg_addr_t s1;
		reg_addr_t s2;
		op = alu_ops[pick(11)];
		d = reg_addr_t'(lo + pick(hi - lo + 1));
		s1 = reg_addr_t'(lo + pick(hi - lo + 1));
		s2 = reg_addr_t'(lo + pick(hi - lo + 1));
		if (op == OP_ADDI || op == OP_ANDI || op == OP_ORI) begin
			emit(imm_form(op, d, s1, random_half()));
		end else begin
			emit(reg_form(op, d, s1, s2));
		end
	endtask

	task automatic seed_registers(input int lo, input int hi);
		for (int i = lo; i <= hi; i++) begin
			emit(imm_form(OP_LLI, reg_addr_t'(i), 5'd0, random_half()));
			emit(imm_form(OP_LUI, reg_addr_t'(i), 5'd0, random_half()));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// instruction-set model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic cond_holds(logic [2:0] c, logic z, logic s, logic v);
		case (c)
			COND_NE: return !z;
			COND_EQ: return z;
			COND_GT: return !z && !s;
			COND_LT: return s;
			COND_GE: return !s;
			COND_LE: return z || s;
			COND_OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic model_program();
		word_t      regs [32];
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      imm;
		word_t      r;
		longint     wide;
		opcode_t    op;
		reg_addr_t  d;
		logic [2:0] cond;
		logic       z;
		logic       s;
		logic       v;
		logic       ovf;
		logic       sets_cc;
		logic       writes;
		logic       done;
		int         pc;
		int         next_pc;
		int         link;
		int         steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		z = 1'b0;
		s = 1'b0;
		v = 1'b0;
		done = 1'b0;
		pc = 0;
		link = 0;
		steps = 0;
		while (!done && steps < MODEL_STEPS && pc < PROG_LEN) begin
			ins = prog[pc];
			op = ins[31:27];
			d = ins[26:22];
			cond = ins[26:24];
			a = regs[ins[21:17]];
			b = regs[ins[16:12]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ovf = 1'b0;
			sets_cc = 1'b1;
			writes = 1'b1;
			r = '0;
			next_pc = (pc + 1) & 2047;
			if (op == OP_ADDI || op == OP_ANDI || op == OP_ORI) begin
				b = imm;
			end
			case (op)
				OP_ADD, OP_ADDI: begin
					wide = longint'($signed(a)) + longint'($signed(b));
					r = wide[31:0];
					ovf = wide != longint'($signed(r));
				end
				OP_SUB: begin
					wide = longint'($signed(a)) - longint'($signed(b));
					r = wide[31:0];
					ovf = wide != longint'($signed(r));
				end
				OP_AND, OP_ANDI: r = a & b;
				OP_OR, OP_ORI: r = a | b;
				OP_XOR: r = a ^ b;
				OP_SLL: r = a << b[4:0];
				OP_SRL: r = a >> b[4:0];
				OP_SRA: r = word_t'($signed(a) >>> b[4:0]);
				OP_LLI: begin
					sets_cc = 1'b0;
					r = {regs[d][31:16], ins[15:0]};
				end
				OP_LUI: begin
					sets_cc = 1'b0;
					r = {ins[15:0], regs[d][15:0]};
				end
				OP_B, OP_BL: begin
					sets_cc = 1'b0;
					writes = 1'b0;
					if (op == OP_B && cond == COND_ALWAYS && ins[15:0] == 16'hffff) begin
						done = 1'b1;
					end else if (cond_holds(cond, z, s, v)) begin
						if (op == OP_BL) begin
							link = next_pc;
						end
						next_pc = (pc + 1 + int'($signed(ins[15:0]))) & 2047;
					end
				end
				OP_RET: begin
					sets_cc = 1'b0;
					writes = 1'b0;
					next_pc = link;
				end
				default: begin
					sets_cc = 1'b0;
					writes = 1'b0;
				end
			endcase
			if (sets_cc) begin
				z = (r == '0);
				s = r[31];
				v = ovf;
			end
			// r0 writes still retire, the register stays zero
			if (writes) begin
				exp_dest.push_back(d);
				exp_data.push_back(r);
				if (d != '0) begin
					regs[d] = r;
				end
			end
			pc = next_pc;
			steps++;
		end
		if (!done) begin
			$display("model stopped at address %0d after %0d steps without reaching the end loop",
				pc, steps);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// running a test
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_cpu();
		@(posedge clk);
		#1;
		run = 1'b0;
		rst_n = 1'b0;
		exp_dest.delete();
		exp_data.delete();
		got = 0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = iaddr_t'(i);
			imem_data = prog[i];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		if (errors == start) begin
			$display("test %s: passed, %0d writes retired", name, got);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - start);
		end
	endtask

	task automatic check_program(input string name);
		int start;
		int cycles;
		start = errors;
		reset_cpu();
		load_program();
		model_program();
		run = 1'b1;
		cycles = 0;
		while (got < exp_dest.size() && cycles < RUN_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (got >= exp_dest.size()) else begin
			$display("%s timed out after %0d cycles with %0d of %0d writes retired",
				name, cycles, got, exp_dest.size());
			errors++;
		end
		// extra retires are caught by the monitor
		repeat (QUIET_CYCLES) @(posedge clk);
		report_test(name, start);
	endtask

	initial begin
		int        start;
		int        off;
		reg_addr_t d;
		rst_n = 1'b0;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		got = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		plen = 0;

		// loading with run low must stay quiet
		start = errors;
		reset_cpu();
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = $random(seed);
		end
		load_program();
		repeat (QUIET_CYCLES) @(posedge clk);
		report_test("reset_idle", start);

		clear_program();
		seed_registers(1, 4);
		for (int i = 0; i < 40; i++) begin
			random_alu_op(1, 4);
		end
		finish_program();
		check_program("alu_random");

		clear_program();
		seed_registers(1, 4);
		for (int i = 0; i < 12; i++) begin
			d = reg_addr_t'(1 + pick(4));
			if (pick(2) == 0) begin
				emit(imm_form(OP_LLI, d, 5'd0, random_half()));
				emit(imm_form(OP_LUI, d, 5'd0, random_half()));
			end else begin
				emit(imm_form(OP_LUI, d, 5'd0, random_half()));
				emit(imm_form(OP_LLI, d, 5'd0, random_half()));
			end
			random_alu_op(1, 4);
			random_alu_op(1, 4);
		end
		finish_program();
		check_program("lli_lui_constants");

		// every branch sits right behind a flag update
		clear_program();
		seed_registers(1, 4);
		for (int round = 0; round < 3; round++) begin
			for (int c = 0; c < 8; c++) begin
				random_alu_op(1, 4);
				off = 1 + pick(3);
				emit(branch_form(OP_B, 3'(c), 16'(off)));
				for (int k = 0; k < off; k++) begin
					random_alu_op(1, 4);
				end
			end
		end
		finish_program();
		check_program("branch_conditions");

		// two calls into one subroutine at address 10
		clear_program();
		emit(imm_form(OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(branch_form(OP_BL, COND_ALWAYS, 16'd8));
		emit(reg_form(OP_ADD, 5'd3, 5'd1, 5'd2));
		emit(branch_form(OP_BL, COND_ALWAYS, 16'd6));
		emit(reg_form(OP_XOR, 5'd4, 5'd3, 5'd2));
		finish_program();
		plen = 10;
		emit(imm_form(OP_ADDI, 5'd2, 5'd2, 16'd7));
		emit(reg_form(OP_SUB, 5'd5, 5'd2, 5'd1));
		emit(reg_form(OP_RET, 5'd0, 5'd0, 5'd0));
		emit(imm_form(OP_ADDI, 5'd6, 5'd0, 16'd99));
		check_program("call_return");

		clear_program();
		seed_registers(1, 2);
		emit(imm_form(OP_ADDI, 5'd0, 5'd1, 16'h0123));
		emit(reg_form(OP_ADD, 5'd3, 5'd0, 5'd0));
		emit(imm_form(OP_LLI, 5'd0, 5'd0, 16'hbeef));
		emit(reg_form(OP_OR, 5'd4, 5'd0, 5'd1));
		for (int i = 0; i < 24; i++) begin
			if (pick(4) == 0) begin
				d = reg_addr_t'(pick(3));
				emit(imm_form(pick(2) == 0 ? OP_LLI : OP_LUI, d, 5'd0, random_half()));
			end else begin
				random_alu_op(0, 2);
			end
		end
		finish_program();
		check_program("zero_register");

		$display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- compile.f
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/instruction_fetch.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/cpu_top.sv
verification/cpu_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module cpu_tb -f compile.f -o cpu_tb_sim
	./obj_dir/cpu_tb_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
